/* dtlb.f */
rtl/dtlb_pkg.sv
rtl/dtlb_entry_store.sv
rtl/dtlb_walk_ctrl.sv
rtl/dtlb_access_check.sv
rtl/dtlb.sv
tests/dtlb_sva.sv
tests/tb_dtlb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_dtlb
FILELIST  := dtlb.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(OBJ_DIR)

/* tests/dtlb_golden.txt */
# op: 0 clear, 1 request without walk, 2 request with walk, 3 walk with clear pulse
# op pg vpn wr user | walker ppn pd pt | expected ppn flags pf (all hex)
1 0 12345 0 0 00000 0 0 12345 3 0
1 0 0abcd 1 1 00000 0 0 0abcd 3 0
2 1 00010 0 0 80010 b 7 80010 f 0
1 1 00010 0 0 00000 0 0 80010 f 0
2 1 00020 0 0 80020 3 3 80020 3 0
1 1 00010 0 0 00000 0 0 80010 f 0
2 1 00030 0 0 80030 1 3 80030 1 0
1 1 00010 0 0 00000 0 0 80010 f 0
2 1 00020 0 0 80021 3 3 80021 3 0
2 1 00041 0 0 90041 3 2 90041 2 1
1 1 00041 0 0 00000 0 0 90041 2 1
2 1 00052 0 1 90052 3 7 90052 7 1
1 1 00052 0 0 00000 0 0 90052 7 0
2 1 00063 1 1 90063 1 3 90063 1 1
1 1 00063 0 1 00000 0 0 90063 1 0
0 0 00000 0 0 00000 0 0 00000 0 0
2 1 00010 0 0 80012 3 3 80012 3 0
1 1 00010 0 0 00000 0 0 80012 3 0
3 1 00052 0 0 90152 3 3 90152 3 0
2 1 00010 0 0 80013 1 1 80013 1 0
1 1 00010 1 0 00000 0 0 80013 1 1
2 1 00052 0 0 90252 3 3 90252 3 0
1 0 00010 1 1 00000 0 0 00010 3 0
1 1 00010 1 0 00000 0 0 80013 1 1

/* tests/tb_dtlb.sv */
module tb_dtlb;

  localparam int CLK_PERIOD     = 10;
  localparam int MAX_LINES      = 64;
  localparam int CYCLES_PER_LINE = 20;

  logic                 clkrst_mem_clk = 1'b0;
  logic                 clkrst_mem_rst_n;
  dtlb_pkg::dtlb_req_t  req;
  logic                 re;
  logic                 paging_on;
  logic                 clear;
  dtlb_pkg::ppn_t       phys_ppn;
  dtlb_pkg::pte_flags_t flags;
  logic                 pf;
  logic                 ready;
  dtlb_pkg::vpn_t       ptw_vpn;
  logic                 ptw_re;
  dtlb_pkg::ptw_resp_t  ptw_resp;
  logic                 ptw_ready;

  // Golden columns with one entry per data line
  logic [3:0]  g_op    [MAX_LINES];
  logic        g_pg    [MAX_LINES];
  logic [19:0] g_vpn   [MAX_LINES];
  logic        g_wr    [MAX_LINES];
  logic        g_usr   [MAX_LINES];
  logic [19:0] g_wppn  [MAX_LINES];
  logic [3:0]  g_pd    [MAX_LINES];
  logic [3:0]  g_pt    [MAX_LINES];
  logic [19:0] g_eppn  [MAX_LINES];
  logic [3:0]  g_eflags[MAX_LINES];
  logic        g_epf   [MAX_LINES];

  int             vec_count;
  logic           vec_loaded;
  int             cur_idx;
  logic           walk_expected;
  // Walker bookkeeping
  int             walk_count;
  int             last_walk_lat;
  dtlb_pkg::vpn_t walk_vpn;
  int             seed;

  always #(CLK_PERIOD / 2) clkrst_mem_clk = ~clkrst_mem_clk;

  dtlb #(
    .SET_BITS (4)
  ) UUT (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .req              (req),
    .re               (re),
    .paging_on        (paging_on),
    .clear            (clear),
    .phys_ppn         (phys_ppn),
    .flags            (flags),
    .pf               (pf),
    .ready            (ready),
    .ptw_vpn          (ptw_vpn),
    .ptw_re           (ptw_re),
    .ptw_resp         (ptw_resp),
    .ptw_ready        (ptw_ready)
  );

  task automatic check_value(input string what, input int line,
                             input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at time %0t: line %0d %s is %0h, expected %0h",
               $time, line, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic load_golden();
    int          fd;
    int          n;
    string       line;
    logic [31:0] t_op, t_pg, t_vpn, t_wr, t_usr, t_wppn;
    logic [31:0] t_pd, t_pt, t_eppn, t_efl, t_epf;
    fd = $fopen("tests/dtlb_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open tests/dtlb_golden.txt for reading");
      $display("RESULT: FAIL");
      $fatal(1, "Missing golden file");
    end
    vec_count = 0;
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", t_op, t_pg, t_vpn,
                  t_wr, t_usr, t_wppn, t_pd, t_pt, t_eppn, t_efl, t_epf);
      // Header and blank lines do not scan
      if (n == 11 && vec_count < MAX_LINES) begin
        g_op[vec_count]     = t_op[3:0];
        g_pg[vec_count]     = t_pg[0];
        g_vpn[vec_count]    = t_vpn[19:0];
        g_wr[vec_count]     = t_wr[0];
        g_usr[vec_count]    = t_usr[0];
        g_wppn[vec_count]   = t_wppn[19:0];
        g_pd[vec_count]     = t_pd[3:0];
        g_pt[vec_count]     = t_pt[3:0];
        g_eppn[vec_count]   = t_eppn[19:0];
        g_eflags[vec_count] = t_efl[3:0];
        g_epf[vec_count]    = t_epf[0];
        vec_count++;
      end
    end
    $fclose(fd);
    if (vec_count == 0) begin
      $display("The golden file holds no usable data lines");
      $display("RESULT: FAIL");
      $fatal(1, "Empty golden file");
    end
    vec_loaded = 1'b1;
  endtask

  task automatic pulse_clear();
    @(posedge clkrst_mem_clk);
    #1;
    clear = 1'b1;
    @(posedge clkrst_mem_clk);
    #1;
    clear = 1'b0;
  endtask

  task automatic run_request(input int idx);
    int cycles;
    int walks_before;
    walks_before = walk_count;
    @(posedge clkrst_mem_clk);
    #1;
    req.vpn       = g_vpn[idx];
    req.is_write  = g_wr[idx];
    req.user_mode = g_usr[idx];
    paging_on     = g_pg[idx];
    re            = 1'b1;
    // Hold the request until a cycle with ready high
    @(negedge clkrst_mem_clk);
    while (!ready) begin
      @(negedge clkrst_mem_clk);
    end
    @(posedge clkrst_mem_clk);
    #1;
    re     = 1'b0;
    cycles = 0;
    if (g_op[idx] == 4'd3) begin
      // Clear pulse lands while the walk runs
      @(posedge clkrst_mem_clk);
      #1;
      clear = 1'b1;
      @(posedge clkrst_mem_clk);
      #1;
      clear  = 1'b0;
      cycles = 2;
    end
    // Result sits in the first later cycle with ready high
    @(negedge clkrst_mem_clk);
    cycles++;
    while (!ready) begin
      @(negedge clkrst_mem_clk);
      cycles++;
    end
    check_value("phys_ppn", idx, 32'(phys_ppn), 32'(g_eppn[idx]));
    check_value("flags", idx, 32'(flags), 32'(g_eflags[idx]));
    check_value("pf", idx, 32'(pf), 32'(g_epf[idx]));
    if (walk_expected) begin
      check_value("walk count", idx, walk_count - walks_before, 1);
      check_value("walk vpn", idx, 32'(walk_vpn), 32'(g_vpn[idx]));
      // Ready returns one cycle after the walker answer
      check_value("miss latency", idx, cycles, last_walk_lat + 2);
    end else begin
      check_value("latency", idx, cycles, 1);
    end
  endtask

  // Walker model answers each strobe after 1 to 4 cycles
  initial begin
    seed          = 32'h3c89_a094;
    walk_count    = 0;
    last_walk_lat = 0;
    walk_vpn      = '0;
    ptw_resp      = '0;
    ptw_ready     = 1'b0;
    forever begin
      @(negedge clkrst_mem_clk);
      if (clkrst_mem_rst_n && ptw_re) begin
        if (!walk_expected) begin
          $display("Walker strobe seen for golden line %0d, which expects a hit", cur_idx);
          $display("RESULT: FAIL");
          $fatal(1, "Unexpected page table walk");
        end
        walk_count++;
        walk_vpn      = ptw_vpn;
        last_walk_lat = ($random(seed) & 3) + 1;
        repeat (last_walk_lat) @(posedge clkrst_mem_clk);
        #1;
        ptw_resp.ppn           = g_wppn[cur_idx];
        ptw_resp.pagedir_flags = g_pd[cur_idx];
        ptw_resp.pagetab_flags = g_pt[cur_idx];
        ptw_ready              = 1'b1;
        @(posedge clkrst_mem_clk);
        #1;
        ptw_ready = 1'b0;
      end
    end
  end

  // Watchdog scaled by the number of golden lines
  initial begin
    wait (vec_loaded);
    #(vec_count * CYCLES_PER_LINE * CLK_PERIOD);
    $display("Timeout: golden lines not finished within %0d cycles",
             vec_count * CYCLES_PER_LINE);
    $display("RESULT: FAIL");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    clkrst_mem_rst_n = 1'b0;
    req              = '0;
    re               = 1'b0;
    paging_on        = 1'b0;
    clear            = 1'b0;
    cur_idx          = 0;
    walk_expected    = 1'b0;
    vec_loaded       = 1'b0;
    load_golden();
    repeat (2) @(posedge clkrst_mem_clk);
    #1;
    clkrst_mem_rst_n = 1'b1;
    // Idle outputs straight after reset
    @(negedge clkrst_mem_clk);
    check_value("ready after reset", -1, 32'(ready), 32'd1);
    check_value("ptw_re after reset", -1, 32'(ptw_re), 32'd0);
    check_value("pf after reset", -1, 32'(pf), 32'd0);
    for (int i = 0; i < vec_count; i++) begin
      cur_idx       = i;
      walk_expected = (g_op[i] == 4'd2) || (g_op[i] == 4'd3);
      if (g_op[i] == 4'd0) begin
        pulse_clear();
      end else begin
        run_request(i);
      end
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// Assertions sit in the controller where the state lives
bind dtlb_walk_ctrl dtlb_sva u_sva (
  .clkrst_mem_clk   (clkrst_mem_clk),
  .clkrst_mem_rst_n (clkrst_mem_rst_n),
  .state            (state),
  .ready            (ready),
  .ptw_re           (ptw_re),
  .ptw_vpn          (ptw_vpn),
  .ptw_ready        (ptw_ready)
);

/* tests/dtlb_sva.sv */
module dtlb_sva (
  input logic                  clkrst_mem_clk,
  input logic                  clkrst_mem_rst_n,
  input dtlb_pkg::walk_state_e state,
  input logic                  ready,
  input logic                  ptw_re,
  input dtlb_pkg::vpn_t        ptw_vpn,
  input logic                  ptw_ready
);

  // Walker strobe lasts one cycle only
  a_ptw_re_single: assert property (
    @(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
    ptw_re |=> !ptw_re
  ) else $error("ptw_re high on two consecutive cycles");

  // Walk address held from the strobe up to the walker answer
  a_ptw_vpn_stable: assert property (
    @(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
    (ptw_re || ((state == dtlb_pkg::ST_WALK) && !ptw_ready)) |=> $stable(ptw_vpn)
  ) else $error("ptw_vpn changed while a walk was outstanding");

  // No request taken during a walk
  a_ready_low_in_walk: assert property (
    @(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
    (state == dtlb_pkg::ST_WALK) |-> !ready
  ) else $error("ready high while the controller is walking");

endmodule

/* rtl/dtlb.sv */
module dtlb #(
  parameter int SET_BITS = 4
) (
  input  logic                  clkrst_mem_clk,
  input  logic                  clkrst_mem_rst_n,
  // Requester side
  input  dtlb_pkg::dtlb_req_t   req,
  input  logic                  re,
  input  logic                  paging_on,
  input  logic                  clear,
  output dtlb_pkg::ppn_t        phys_ppn,
  output dtlb_pkg::pte_flags_t  flags,
  output logic                  pf,
  output logic                  ready,
  // Page table walker side
  output dtlb_pkg::vpn_t        ptw_vpn,
  output logic                  ptw_re,
  input  dtlb_pkg::ptw_resp_t   ptw_resp,
  input  logic                  ptw_ready
);

  // Store and controller handshake
  logic                  hit;
  logic                  touch;
  logic                  fill;
  logic                  flush;
  dtlb_pkg::vpn_t        read_vpn;
  dtlb_pkg::vpn_t        fill_vpn;
  dtlb_pkg::dtlb_entry_t rd_entry;
  dtlb_pkg::dtlb_entry_t fill_entry;

  // Latched request for the result stage
  dtlb_pkg::dtlb_req_t   req_q;
  logic                  re_q;
  logic                  paging_q;

  dtlb_entry_store #(
    .SET_BITS (SET_BITS)
  ) u_store (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .read_vpn         (read_vpn),
    .hit              (hit),
    .rd_entry         (rd_entry),
    .touch            (touch),
    .fill             (fill),
    .fill_vpn         (fill_vpn),
    .fill_entry       (fill_entry),
    .flush            (flush)
  );

  dtlb_walk_ctrl u_ctrl (
    .clkrst_mem_clk   (clkrst_mem_clk),
    .clkrst_mem_rst_n (clkrst_mem_rst_n),
    .req              (req),
    .re               (re),
    .paging_on        (paging_on),
    .clear            (clear),
    .hit              (hit),
    .read_vpn         (read_vpn),
    .touch            (touch),
    .fill             (fill),
    .fill_vpn         (fill_vpn),
    .flush            (flush),
    .req_q            (req_q),
    .re_q             (re_q),
    .paging_q         (paging_q),
    .ready            (ready),
    .ptw_vpn          (ptw_vpn),
    .ptw_re           (ptw_re),
    .ptw_ready        (ptw_ready)
  );

  dtlb_access_check u_check (
    .ptw_resp   (ptw_resp),
    .fill_entry (fill_entry),
    .rd_entry   (rd_entry),
    .req_q      (req_q),
    .re_q       (re_q),
    .paging_q   (paging_q),
    .phys_ppn   (phys_ppn),
    .flags      (flags),
    .pf         (pf)
  );

endmodule

/* rtl/dtlb_access_check.sv */
module dtlb_access_check (
  input  dtlb_pkg::ptw_resp_t    ptw_resp,
  output dtlb_pkg::dtlb_entry_t  fill_entry,
  input  dtlb_pkg::dtlb_entry_t  rd_entry,
  input  dtlb_pkg::dtlb_req_t    req_q,
  input  logic                   re_q,
  input  logic                   paging_q,
  output dtlb_pkg::ppn_t         phys_ppn,
  output dtlb_pkg::pte_flags_t   flags,
  output logic                   pf
);

  dtlb_pkg::pte_flags_t pd;
  dtlb_pkg::pte_flags_t pt;

  assign pd = ptw_resp.pagedir_flags;
  assign pt = ptw_resp.pagetab_flags;

  // Present and writeable need both levels
  // Kernel and global come from either level
  always_comb begin
    fill_entry.ppn = ptw_resp.ppn;
    fill_entry.flags[dtlb_pkg::FLAG_PRESENT] =
      pd[dtlb_pkg::FLAG_PRESENT] & pt[dtlb_pkg::FLAG_PRESENT];
    fill_entry.flags[dtlb_pkg::FLAG_WRITEABLE] =
      pd[dtlb_pkg::FLAG_WRITEABLE] & pt[dtlb_pkg::FLAG_WRITEABLE];
    fill_entry.flags[dtlb_pkg::FLAG_KERNEL] =
      pd[dtlb_pkg::FLAG_KERNEL] | pt[dtlb_pkg::FLAG_KERNEL];
    fill_entry.flags[dtlb_pkg::FLAG_GLOBAL] =
      pd[dtlb_pkg::FLAG_GLOBAL] | pt[dtlb_pkg::FLAG_GLOBAL];
  end

  // Identity mapping when paging was off for this request
  assign phys_ppn = paging_q ? rd_entry.ppn : req_q.vpn;
  assign flags    = paging_q ? rd_entry.flags : dtlb_pkg::PASSTHRU_FLAGS;

  // Each request checked against its own flags
  always_comb begin
    pf = 1'b0;
    if (re_q) begin
      if (!flags[dtlb_pkg::FLAG_PRESENT]) begin
        pf = 1'b1;
      end else if (flags[dtlb_pkg::FLAG_KERNEL] && req_q.user_mode) begin
        pf = 1'b1;
      end else if (req_q.is_write && !flags[dtlb_pkg::FLAG_WRITEABLE]) begin
        pf = 1'b1;
      end
    end
  end

endmodule

/* rtl/dtlb_walk_ctrl.sv */
module dtlb_walk_ctrl (
  input  logic                 clkrst_mem_clk,
  input  logic                 clkrst_mem_rst_n,
  input  dtlb_pkg::dtlb_req_t  req,
  input  logic                 re,
  input  logic                 paging_on,
  input  logic                 clear,
  input  logic                 hit,
  output dtlb_pkg::vpn_t       read_vpn,
  output logic                 touch,
  output logic                 fill,
  output dtlb_pkg::vpn_t       fill_vpn,
  output logic                 flush,
  output dtlb_pkg::dtlb_req_t  req_q,
  output logic                 re_q,
  output logic                 paging_q,
  output logic                 ready,
  output dtlb_pkg::vpn_t       ptw_vpn,
  output logic                 ptw_re,
  input  logic                 ptw_ready
);

  dtlb_pkg::walk_state_e state;
  dtlb_pkg::walk_state_e state_nxt;

  // Clear seen while busy, applied once back in idle
  logic clear_pend;

  // Request taken at this edge
  logic accept;

  // Ready in idle, or in compare when the latched request hit
  assign ready = (state == dtlb_pkg::ST_IDLE) ||
                 ((state == dtlb_pkg::ST_COMPARE) && hit);

  assign accept = ready & re;

  // Read the incoming page on accept so the hit is known next cycle
  assign read_vpn = accept ? req.vpn : req_q.vpn;

  // Latched page stays put for the whole walk
  assign ptw_vpn  = req_q.vpn;
  assign fill_vpn = req_q.vpn;

  // Invalidate only from idle
  assign flush = (clear | clear_pend) & (state == dtlb_pkg::ST_IDLE);

  always_comb begin
    state_nxt = state;
    touch     = 1'b0;
    fill      = 1'b0;
    ptw_re    = 1'b0;
    case (state)
      dtlb_pkg::ST_IDLE: begin
        // Paging off is answered without leaving idle
        if (accept && paging_on) begin
          state_nxt = dtlb_pkg::ST_COMPARE;
        end
      end
      dtlb_pkg::ST_COMPARE: begin
        if (hit) begin
          touch = 1'b1;
          // Back-to-back hits stay in compare
          if (accept && paging_on) begin
            state_nxt = dtlb_pkg::ST_COMPARE;
          end else begin
            state_nxt = dtlb_pkg::ST_IDLE;
          end
        end else begin
          // Miss starts the walk with a single strobe
          ptw_re    = 1'b1;
          state_nxt = dtlb_pkg::ST_WALK;
        end
      end
      dtlb_pkg::ST_WALK: begin
        // Fill is read back write-first, result shows in idle
        if (ptw_ready) begin
          fill      = 1'b1;
          state_nxt = dtlb_pkg::ST_IDLE;
        end
      end
      default: begin
        state_nxt = dtlb_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      state      <= dtlb_pkg::ST_IDLE;
      clear_pend <= 1'b0;
      re_q       <= 1'b0;
      paging_q   <= 1'b0;
    end else begin
      state <= state_nxt;
      if (flush) begin
        clear_pend <= 1'b0;
      end else if (clear) begin
        clear_pend <= 1'b1;
      end
      // Request valid tracks every ready cycle
      // so pf drops when nothing was asked
      if (ready) begin
        re_q <= re;
      end
      if (accept) begin
        paging_q <= paging_on;
      end
    end
  end

  // Request payload
  always_ff @(posedge clkrst_mem_clk) begin
    if (accept) begin
      req_q <= req;
    end
  end

endmodule

/* rtl/dtlb_entry_store.sv */
module dtlb_entry_store #(
  parameter int SET_BITS = 4
) (
  input  logic                   clkrst_mem_clk,
  input  logic                   clkrst_mem_rst_n,
  input  dtlb_pkg::vpn_t         read_vpn,
  output logic                   hit,
  output dtlb_pkg::dtlb_entry_t  rd_entry,
  input  logic                   touch,
  input  logic                   fill,
  input  dtlb_pkg::vpn_t         fill_vpn,
  input  dtlb_pkg::dtlb_entry_t  fill_entry,
  input  logic                   flush
);

  localparam int NUM_SETS = 1 << SET_BITS;
  localparam int TAG_BITS = 20 - SET_BITS;

  typedef logic [SET_BITS-1:0] set_idx_t;
  typedef logic [TAG_BITS-1:0] tag_t;

  // Per-set valid bits for the two ways
  logic [NUM_SETS-1:0][1:0] valid;
  // Way to be replaced next in each set
  logic [NUM_SETS-1:0]      evict;

  // Tag and translation arrays
  tag_t                  tags    [NUM_SETS][2];
  dtlb_pkg::dtlb_entry_t entries [NUM_SETS][2];

  // Set index is the low VPN bits, tag is the rest
  set_idx_t rd_set;
  tag_t     rd_tag;
  set_idx_t fill_set;
  tag_t     fill_tag;
  logic     victim;

  assign rd_set   = read_vpn[SET_BITS-1:0];
  assign rd_tag   = read_vpn[19:SET_BITS];
  assign fill_set = fill_vpn[SET_BITS-1:0];
  assign fill_tag = fill_vpn[19:SET_BITS];
  assign victim   = evict[fill_set];

  // Contents of the read set as seen after this edge
  logic [1:0]            way_valid;
  tag_t                  way_tag   [2];
  dtlb_pkg::dtlb_entry_t way_entry [2];
  logic [1:0]            way_hit;

  // Registered read result
  logic                  hit_q;
  logic                  hit_way_q;
  set_idx_t              rd_set_q;
  dtlb_pkg::dtlb_entry_t rd_entry_q;

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      // A flush at this edge invalidates the read too
      way_valid[w] = valid[rd_set][w] & ~flush;
      way_tag[w]   = tags[rd_set][w];
      way_entry[w] = entries[rd_set][w];
      // Write-first bypass of a fill into the same set and way
      if (fill && (fill_set == rd_set) && (victim == 1'(w))) begin
        way_valid[w] = 1'b1;
        way_tag[w]   = fill_tag;
        way_entry[w] = fill_entry;
      end
      way_hit[w] = way_valid[w] && (way_tag[w] == rd_tag);
    end
  end

  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      hit_q <= 1'b0;
    end else begin
      hit_q <= |way_hit;
    end
  end

  // Read payload, way 1 wins only when it is the hitting way
  always_ff @(posedge clkrst_mem_clk) begin
    hit_way_q  <= way_hit[1];
    rd_set_q   <= rd_set;
    rd_entry_q <= way_hit[1] ? way_entry[1] : way_entry[0];
  end

  // Valid bits and eviction bits
  always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
    if (!clkrst_mem_rst_n) begin
      valid <= '0;
      evict <= '0;
    end else begin
      if (flush) begin
        valid <= '0;
      end else if (fill) begin
        valid[fill_set][victim] <= 1'b1;
      end
      // Hit moves the bit away from the way just used
      if (touch) begin
        evict[rd_set_q] <= ~hit_way_q;
      end
      // Fill toggles the bit of the filled set
      if (fill) begin
        evict[fill_set] <= ~victim;
      end
    end
  end

  // Tag and translation writes on a fill
  always_ff @(posedge clkrst_mem_clk) begin
    if (fill) begin
      tags[fill_set][victim]    <= fill_tag;
      entries[fill_set][victim] <= fill_entry;
    end
  end

  assign hit      = hit_q;
  assign rd_entry = rd_entry_q;

endmodule

/* rtl/dtlb_pkg.sv */
package dtlb_pkg;

  // Virtual page number holds address bits 31 to 12
  typedef logic [19:0] vpn_t;

  // Physical page number as returned by the walker
  typedef logic [19:0] ppn_t;

  // Page flags in the order given by the bit positions below
  typedef logic [3:0] pte_flags_t;

  // Bit positions within pte_flags_t
  localparam int FLAG_PRESENT   = 0;
  localparam int FLAG_WRITEABLE = 1;
  localparam int FLAG_KERNEL    = 2;
  localparam int FLAG_GLOBAL    = 3;

  // Reported when paging is off
  // Present and writeable only
  localparam pte_flags_t PASSTHRU_FLAGS = 4'b0011;

  // One lookup request from the memory unit
  typedef struct packed {
    vpn_t vpn;
    logic is_write;
    logic user_mode;
  } dtlb_req_t;

  // Translation held per way
  typedef struct packed {
    pte_flags_t flags;
    ppn_t       ppn;
  } dtlb_entry_t;

  // Walker answer with directory and table flags still separate
  typedef struct packed {
    ppn_t       ppn;
    pte_flags_t pagedir_flags;
    pte_flags_t pagetab_flags;
  } ptw_resp_t;

  // Lookup controller states
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_COMPARE = 2'd1,
    ST_WALK    = 2'd2
  } walk_state_e;

endpackage
